//--- build.f
source/game_pkg.sv
source/seven_seg_decoder.sv
source/sequence_rom.sv
source/play_detector.sv
source/game_datapath.sv
source/game_control.sv
source/memory_game.sv
test/memory_game_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the memory game testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f build.f --top-module memory_game_tb \
    --Mdir obj_dir -o memory_game_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/memory_game_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

echo "Simulation finished"
exit 0

//--- source/game_control.sv
`timescale 1ns/1ns

module game_control (
    input  logic                  clock,
    input  logic                  arst_n,
    input  logic                  jogar,
    input  logic                  move_valid,
    input  logic                  move_match,
    input  logic                  address_at_round,
    input  logic                  round_at_last,
    input  logic                  timeout_done,
    output logic                  clear_address,
    output logic                  count_address,
    output logic                  clear_round,
    output logic                  count_round,
    output logic                  clear_timeout,
    output logic                  count_timeout,
    output logic                  clear_move,
    output logic                  latch_level,
    output logic                  ganhou,
    output logic                  perdeu,
    output logic                  timeout,
    output logic                  pronto,
    output game_pkg::game_state_t state
);

    import game_pkg::*;

    game_state_t next_state;

    // ------------------------------------------------------------
    // State register
    // ------------------------------------------------------------
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

    // ------------------------------------------------------------
    // Next state
    // ------------------------------------------------------------
    always_comb begin
        next_state = state;
        case (state)
            st_idle, st_won, st_lost, st_timed_out: begin
                if (jogar) begin
                    next_state = st_init;
                end
            end
            st_init: begin
                next_state = st_wait_move;
            end
            st_wait_move: begin
                // A move wins over a timeout on the same cycle
                if (move_valid) begin
                    next_state = st_compare;
                end else if (timeout_done) begin
                    next_state = st_timed_out;
                end
            end
            st_compare: begin
                if (!move_match) begin
                    next_state = st_lost;
                end else if (!address_at_round) begin
                    next_state = st_next_address;
                end else if (round_at_last) begin
                    next_state = st_won;
                end else begin
                    next_state = st_next_round;
                end
            end
            st_next_address: begin
                next_state = st_wait_move;
            end
            st_next_round: begin
                next_state = st_wait_move;
            end
            default: begin
                next_state = st_idle;
            end
        endcase
    end

    // Datapath controls, decoded from the current state
    always_comb begin
        clear_address = 1'b0;
        count_address = 1'b0;
        clear_round   = 1'b0;
        count_round   = 1'b0;
        clear_timeout = 1'b0;
        count_timeout = 1'b0;
        clear_move    = 1'b0;
        latch_level   = 1'b0;
        case (state)
            st_init: begin
                clear_address = 1'b1;
                clear_round   = 1'b1;
                clear_timeout = 1'b1;
                clear_move    = 1'b1;
                latch_level   = 1'b1;
            end
            st_wait_move:    count_timeout = 1'b1;
            st_compare:      clear_timeout = 1'b1;
            st_next_address: count_address = 1'b1;
            st_next_round: begin
                count_round   = 1'b1;
                clear_address = 1'b1;
            end
            default: ;
        endcase
    end

    // ------------------------------------------------------------
    // Result flags, registered so they line up with the state
    // ------------------------------------------------------------
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            ganhou  <= 1'b0;
            perdeu  <= 1'b0;
            timeout <= 1'b0;
            pronto  <= 1'b0;
        end else begin
            ganhou  <= (next_state == st_won);
            perdeu  <= (next_state == st_lost) || (next_state == st_timed_out);
            timeout <= (next_state == st_timed_out);
            pronto  <= (next_state == st_won) || (next_state == st_lost) ||
                       (next_state == st_timed_out);
        end
    end

endmodule

//--- source/game_datapath.sv
`timescale 1ns/1ns

module game_datapath #(
    parameter logic [31:0] timeout_cycles = 32'd5000
) (
    input  logic                            clock,
    input  logic                            arst_n,
    input  logic [game_pkg::move_width-1:0] botoes,
    input  logic                            nivel,
    input  logic                            clear_address,
    input  logic                            count_address,
    input  logic                            clear_round,
    input  logic                            count_round,
    input  logic                            clear_timeout,
    input  logic                            count_timeout,
    input  logic                            clear_move,
    input  logic                            latch_level,
    output logic                            move_valid,
    output logic                            move_match,
    output logic                            address_at_round,
    output logic                            round_at_last,
    output logic                            timeout_done,
    output logic [game_pkg::addr_width-1:0] address,
    output logic [game_pkg::addr_width-1:0] round,
    output logic [game_pkg::move_width-1:0] memory_value,
    output logic [game_pkg::move_width-1:0] move
);

    import game_pkg::*;

    logic                  level;
    logic [addr_width-1:0] last_addr;
    logic [31:0]           timeout_count;

    // ------------------------------------------------------------
    // Button input and sequence memory
    // ------------------------------------------------------------
    play_detector u_play_detector (
        .clock      (clock),
        .arst_n     (arst_n),
        .botoes     (botoes),
        .clear_move (clear_move),
        .move       (move),
        .move_valid (move_valid)
    );

    sequence_rom u_sequence_rom (
        .address (address),
        .value   (memory_value)
    );

    // ------------------------------------------------------------
    // Counters and level latch
    // ------------------------------------------------------------
    // Position inside the current round
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            address <= '0;
        end else if (clear_address) begin
            address <= '0;
        end else if (count_address) begin
            address <= address + 1'b1;
        end
    end

    // Last address of the current round
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            round <= '0;
        end else if (clear_round) begin
            round <= '0;
        end else if (count_round) begin
            round <= round + 1'b1;
        end
    end

    // Cycles spent waiting for a move
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            timeout_count <= '0;
        end else if (clear_timeout) begin
            timeout_count <= '0;
        end else if (count_timeout) begin
            timeout_count <= timeout_count + 32'd1;
        end
    end

    // Level is fixed for the whole game
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            level <= 1'b0;
        end else if (latch_level) begin
            level <= nivel;
        end
    end

    // ------------------------------------------------------------
    // Compares
    // ------------------------------------------------------------
    assign last_addr        = level ? last_addr_long : last_addr_short;
    assign move_match       = (move == memory_value);
    assign address_at_round = (address == round);
    assign round_at_last    = (round == last_addr);

    // Strobe on the last counted cycle, control leaves the wait state
    assign timeout_done = count_timeout && (timeout_count == timeout_cycles - 32'd1);

endmodule

//--- source/game_pkg.sv
package game_pkg;

    // ------------------------------------------------------------
    // Widths shared by datapath, control and top level
    // ------------------------------------------------------------
    localparam int addr_width = 4;
    localparam int move_width = 4;
    localparam int seg_width  = 7;

    // Last ROM address of each level
    localparam logic [addr_width-1:0] last_addr_short = 4'd3;
    localparam logic [addr_width-1:0] last_addr_long  = 4'd15;

    // ------------------------------------------------------------
    // Controller states, the code is shown on the state display
    // ------------------------------------------------------------
    typedef enum logic [3:0] {
        st_idle         = 4'd0,
        st_init         = 4'd1,
        st_wait_move    = 4'd2,
        st_compare      = 4'd3,
        st_next_address = 4'd4,
        st_next_round   = 4'd5,
        st_won          = 4'd6,
        st_lost         = 4'd7,
        st_timed_out    = 4'd8
    } game_state_t;

endpackage

//--- source/memory_game.sv
`timescale 1ns/1ns

module memory_game #(
    parameter logic [31:0] timeout_cycles = 32'd5000
) (
    input  logic                            clock,
    input  logic                            arst_n,
    input  logic                            jogar,
    input  logic                            nivel,
    input  logic [game_pkg::move_width-1:0] botoes,
    output logic                            ganhou,
    output logic                            perdeu,
    output logic                            timeout,
    output logic                            pronto,
    output logic [3:0]                      leds,
    output logic [game_pkg::seg_width-1:0]  db_address,
    output logic [game_pkg::seg_width-1:0]  db_memory,
    output logic [game_pkg::seg_width-1:0]  db_round,
    output logic [game_pkg::seg_width-1:0]  db_state,
    output logic [game_pkg::seg_width-1:0]  db_move,
    output logic                            db_address_at_round,
    output logic                            db_move_match
);

    import game_pkg::*;

    logic                  move_valid;
    logic                  round_at_last;
    logic                  timeout_done;
    logic                  clear_address;
    logic                  count_address;
    logic                  clear_round;
    logic                  count_round;
    logic                  clear_timeout;
    logic                  count_timeout;
    logic                  clear_move;
    logic                  latch_level;
    logic [addr_width-1:0] address;
    logic [addr_width-1:0] round;
    logic [move_width-1:0] memory_value;
    game_state_t           state;

    // ------------------------------------------------------------
    // Datapath and controller
    // ------------------------------------------------------------
    // The registered move also lights the LEDs
    game_datapath #(
        .timeout_cycles (timeout_cycles)
    ) u_game_datapath (
        .clock            (clock),
        .arst_n           (arst_n),
        .botoes           (botoes),
        .nivel            (nivel),
        .clear_address    (clear_address),
        .count_address    (count_address),
        .clear_round      (clear_round),
        .count_round      (count_round),
        .clear_timeout    (clear_timeout),
        .count_timeout    (count_timeout),
        .clear_move       (clear_move),
        .latch_level      (latch_level),
        .move_valid       (move_valid),
        .move_match       (db_move_match),
        .address_at_round (db_address_at_round),
        .round_at_last    (round_at_last),
        .timeout_done     (timeout_done),
        .address          (address),
        .round            (round),
        .memory_value     (memory_value),
        .move             (leds)
    );

    game_control u_game_control (
        .clock            (clock),
        .arst_n           (arst_n),
        .jogar            (jogar),
        .move_valid       (move_valid),
        .move_match       (db_move_match),
        .address_at_round (db_address_at_round),
        .round_at_last    (round_at_last),
        .timeout_done     (timeout_done),
        .clear_address    (clear_address),
        .count_address    (count_address),
        .clear_round      (clear_round),
        .count_round      (count_round),
        .clear_timeout    (clear_timeout),
        .count_timeout    (count_timeout),
        .clear_move       (clear_move),
        .latch_level      (latch_level),
        .ganhou           (ganhou),
        .perdeu           (perdeu),
        .timeout          (timeout),
        .pronto           (pronto),
        .state            (state)
    );

    // ------------------------------------------------------------
    // Debug displays
    // ------------------------------------------------------------
    seven_seg_decoder u_hex_address (.digit(address),      .segments(db_address));
    seven_seg_decoder u_hex_memory  (.digit(memory_value), .segments(db_memory));
    seven_seg_decoder u_hex_round   (.digit(round),        .segments(db_round));
    seven_seg_decoder u_hex_state   (.digit(state),        .segments(db_state));
    seven_seg_decoder u_hex_move    (.digit(leds),         .segments(db_move));

endmodule

//--- source/play_detector.sv
`timescale 1ns/1ns

module play_detector (
    input  logic                            clock,
    input  logic                            arst_n,
    input  logic [game_pkg::move_width-1:0] botoes,
    input  logic                            clear_move,
    output logic [game_pkg::move_width-1:0] move,
    output logic                            move_valid
);

    import game_pkg::*;

    logic [move_width-1:0] botoes_prev;
    logic                  press_edge;

    // Idle to pressed transition
    assign press_edge = (botoes_prev == '0) && (botoes != '0);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            botoes_prev <= '0;
            move_valid  <= 1'b0;
        end else begin
            botoes_prev <= botoes;
            move_valid  <= press_edge;
        end
    end

    // Move register, loaded on the same edge as the strobe
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            move <= '0;
        end else if (clear_move) begin
            move <= '0;
        end else if (press_edge) begin
            move <= botoes;
        end
    end

endmodule

//--- source/sequence_rom.sv
`timescale 1ns/1ns

module sequence_rom (
    input  logic [game_pkg::addr_width-1:0] address,
    output logic [game_pkg::move_width-1:0] value
);

    // ------------------------------------------------------------
    // One-hot button per entry, bit (i + i/4) mod 4
    // ------------------------------------------------------------
    always_comb begin
        case (address)
            // First group walks the buttons in order
            4'd0:  value = 4'b0001;
            4'd1:  value = 4'b0010;
            4'd2:  value = 4'b0100;
            4'd3:  value = 4'b1000;
            // Each later group starts one button further on
            4'd4:  value = 4'b0010;
            4'd5:  value = 4'b0100;
            4'd6:  value = 4'b1000;
            4'd7:  value = 4'b0001;
            4'd8:  value = 4'b0100;
            4'd9:  value = 4'b1000;
            4'd10: value = 4'b0001;
            4'd11: value = 4'b0010;
            4'd12: value = 4'b1000;
            4'd13: value = 4'b0001;
            4'd14: value = 4'b0010;
            default: value = 4'b0100;
        endcase
    end

endmodule

//--- source/seven_seg_decoder.sv
`timescale 1ns/1ns

module seven_seg_decoder (
    input  logic [3:0]                     digit,
    output logic [game_pkg::seg_width-1:0] segments
);

    // Active low, bit order gfedcba
    always_comb begin
        case (digit)
            4'h0: segments = 7'b1000000;
            4'h1: segments = 7'b1111001;
            4'h2: segments = 7'b0100100;
            4'h3: segments = 7'b0110000;
            4'h4: segments = 7'b0011001;
            4'h5: segments = 7'b0010010;
            4'h6: segments = 7'b0000010;
            4'h7: segments = 7'b1111000;
            4'h8: segments = 7'b0000000;
            4'h9: segments = 7'b0010000;
            4'ha: segments = 7'b0001000;
            4'hb: segments = 7'b0000011;
            4'hc: segments = 7'b1000110;
            4'hd: segments = 7'b0100001;
            4'he: segments = 7'b0000110;
            default: segments = 7'b0001110;
        endcase
    end

endmodule

//--- test/memory_game_tb.sv
`timescale 1ns/1ns

module memory_game_tb;

    import game_pkg::*;

    localparam logic [31:0] timeout_cycles = 32'd40;
    localparam int          num_scenarios  = 6;

    // Outcome kinds of a scenario row
    localparam int kind_win     = 0;
    localparam int kind_wrong   = 1;
    localparam int kind_timeout = 2;

    typedef struct {
        int level;
        int kind;
        int fault_round;
        int fault_step;
        int exp_ganhou;
        int exp_perdeu;
        int exp_timeout;
        int exp_state;
    } scenario_t;

    logic                  clock;
    logic                  arst_n;
    logic                  jogar;
    logic                  nivel;
    logic [move_width-1:0] botoes;
    logic                  ganhou;
    logic                  perdeu;
    logic                  timeout;
    logic                  pronto;
    logic [3:0]            leds;
    logic [seg_width-1:0]  db_address;
    logic [seg_width-1:0]  db_memory;
    logic [seg_width-1:0]  db_round;
    logic [seg_width-1:0]  db_state;
    logic [seg_width-1:0]  db_move;
    logic                  db_address_at_round;
    logic                  db_move_match;

    scenario_t scenarios [num_scenarios];
    logic [31:0] rng_state   = 32'hb81;
    int          cycle_count = 0;
    int          cycle_limit = 0;

    // Lit segments per hex digit, bit order gfedcba
    logic [6:0] font_on [0:15] = '{
        7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d, 7'h7d, 7'h07,
        7'h7f, 7'h6f, 7'h77, 7'h7c, 7'h39, 7'h5e, 7'h79, 7'h71
    };

    memory_game #(
        .timeout_cycles (timeout_cycles)
    ) u_memory_game (
        .clock               (clock),
        .arst_n              (arst_n),
        .jogar               (jogar),
        .nivel               (nivel),
        .botoes              (botoes),
        .ganhou              (ganhou),
        .perdeu              (perdeu),
        .timeout             (timeout),
        .pronto              (pronto),
        .leds                (leds),
        .db_address          (db_address),
        .db_memory           (db_memory),
        .db_round            (db_round),
        .db_state            (db_state),
        .db_move             (db_move),
        .db_address_at_round (db_address_at_round),
        .db_move_match       (db_move_match)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    // Watchdog on the whole run
    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("Run did not finish within %0d clock cycles", cycle_limit);
            $display("TESTS FAILED");
            $fatal(1, "cycle limit reached");
        end
    end

    // ------------------------------------------------------------
    // Models and helpers
    // ------------------------------------------------------------
    // Entry i has button (i + i/4) mod 4
    function automatic logic [3:0] rom_entry(input int index);
        rom_entry = 4'b0001 << ((index + index / 4) % 4);
    endfunction

    // Active-low display pattern
    function automatic logic [6:0] segments_for(input logic [3:0] digit);
        segments_for = ~font_on[digit];
    endfunction

    function automatic logic [31:0] next_random(input logic [31:0] value);
        logic [31:0] x;
        x = value;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        next_random = x;
    endfunction

    function automatic int presses_in_row(input scenario_t sc);
        int last;
        int count;
        int r;
        last  = (sc.level != 0) ? 15 : 3;
        count = 0;
        if (sc.kind == kind_win) begin
            for (r = 0; r <= last; r++) begin
                count += r + 1;
            end
        end else begin
            for (r = 0; r < sc.fault_round; r++) begin
                count += r + 1;
            end
            count += sc.fault_step;
            if (sc.kind == kind_wrong) begin
                count += 1;
            end
        end
        presses_in_row = count;
    endfunction

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            $display("TESTS FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // Any non-zero nibble except the right one
    task automatic pick_wrong_nibble(input logic [3:0] correct, output logic [3:0] nibble);
        nibble = 4'd0;
        while (nibble == 4'd0 || nibble == correct) begin
            rng_state = next_random(rng_state);
            nibble    = rng_state[3:0];
        end
    endtask

    task automatic wait_for_state(input logic [3:0] digit);
        while (db_state !== segments_for(digit)) begin
            @(negedge clock);
        end
    endtask

    task automatic wait_for_pronto();
        while (pronto !== 1'b1) begin
            @(negedge clock);
        end
    endtask

    // Hold for two cycles, release for four
    task automatic press(input logic [3:0] nibble);
        botoes = nibble;
        repeat (2) @(negedge clock);
        botoes = 4'd0;
        repeat (4) @(negedge clock);
        check("leds", 32'(leds), 32'(nibble));
        check("db_move", 32'(db_move), 32'(segments_for(nibble)));
    endtask

    // ------------------------------------------------------------
    // Scenario table
    // ------------------------------------------------------------
    task automatic load_scenarios();
        //             lvl kind          rnd stp gan per tmo state
        scenarios[0] = '{0, kind_win,     0,  0,  1,  0,  0,  6};
        scenarios[1] = '{1, kind_win,     0,  0,  1,  0,  0,  6};
        scenarios[2] = '{0, kind_wrong,   2,  1,  0,  1,  0,  7};
        scenarios[3] = '{1, kind_wrong,   5,  5,  0,  1,  0,  7};
        scenarios[4] = '{0, kind_timeout, 0,  0,  0,  1,  1,  8};
        scenarios[5] = '{1, kind_timeout, 2,  1,  0,  1,  1,  8};
    endtask

    task automatic run_scenario(input int index);
        scenario_t  sc;
        int         last;
        int         r;
        int         s;
        int         stop;
        int         end_addr;
        logic [3:0] expected;
        logic [3:0] nibble;
        logic [3:0] last_move;
        sc        = scenarios[index];
        last      = (sc.level != 0) ? 15 : 3;
        stop      = 0;
        // A new game starts with the move register cleared
        last_move = 4'd0;
        $display("Scenario %0d: level %0d, kind %0d", index, sc.level, sc.kind);
        nivel = sc.level[0];
        jogar = 1'b1;
        @(negedge clock);
        jogar = 1'b0;
        wait_for_state(4'd2);
        check("pronto", 32'(pronto), 32'd0);
        check("ganhou", 32'(ganhou), 32'd0);
        check("perdeu", 32'(perdeu), 32'd0);
        check("timeout", 32'(timeout), 32'd0);
        for (r = 0; r <= last && stop == 0; r++) begin
            for (s = 0; s <= r && stop == 0; s++) begin
                expected = rom_entry(s);
                check("db_address", 32'(db_address), 32'(segments_for(4'(s))));
                check("db_memory", 32'(db_memory), 32'(segments_for(expected)));
                check("db_round", 32'(db_round), 32'(segments_for(4'(r))));
                check("db_address_at_round", 32'(db_address_at_round), 32'(s == r));
                check("db_move_match", 32'(db_move_match), 32'(last_move == expected));
                if (sc.kind != kind_win && r == sc.fault_round && s == sc.fault_step) begin
                    stop = 1;
                    if (sc.kind == kind_wrong) begin
                        pick_wrong_nibble(expected, nibble);
                        press(nibble);
                        last_move = nibble;
                    end
                end else begin
                    press(expected);
                    last_move = expected;
                    if (!(r == last && s == r)) begin
                        wait_for_state(4'd2);
                    end
                end
            end
            // Round complete but the level goes on
            if (stop == 0 && r < last) begin
                check("pronto", 32'(pronto), 32'd0);
                check("ganhou", 32'(ganhou), 32'd0);
            end
        end
        wait_for_pronto();
        check("ganhou", 32'(ganhou), sc.exp_ganhou);
        check("perdeu", 32'(perdeu), sc.exp_perdeu);
        check("timeout", 32'(timeout), sc.exp_timeout);
        check("db_state", 32'(db_state), 32'(segments_for(4'(sc.exp_state))));
        // Address stays where the game ended
        end_addr = (sc.kind == kind_win) ? last : sc.fault_step;
        check("db_move_match", 32'(db_move_match), 32'(last_move == rom_entry(end_addr)));
    endtask

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------
    initial begin
        int row;
        jogar  = 1'b0;
        nivel  = 1'b0;
        botoes = 4'd0;
        arst_n = 1'b0;
        load_scenarios();
        cycle_limit = 0;
        for (row = 0; row < num_scenarios; row++) begin
            cycle_limit += presses_in_row(scenarios[row]) * 12 + int'(timeout_cycles) + 50;
        end
        repeat (4) @(negedge clock);
        arst_n = 1'b1;
        @(negedge clock);

        // Idle after reset
        check("pronto", 32'(pronto), 32'd0);
        check("ganhou", 32'(ganhou), 32'd0);
        check("perdeu", 32'(perdeu), 32'd0);
        check("timeout", 32'(timeout), 32'd0);
        check("db_state", 32'(db_state), 32'(segments_for(4'd0)));
        check("leds", 32'(leds), 32'd0);

        for (row = 0; row < num_scenarios; row++) begin
            run_scenario(row);
        end
        $display("TESTS PASSED");
        $finish;
    end

endmodule
